// ==== hdl/shift_defs.svh ====
`ifndef SHIFT_DEFS_SVH
`define SHIFT_DEFS_SVH

// Operand and result width
`define SHIFT_WIDTH     32

// Shift amount width, amounts 0 to 31
`define SHIFT_AMT_BITS  5

`endif

// ==== hdl/shift_pkg.sv ====
`include "shift_defs.svh"

package shift_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Operations
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [2:0] {
      OP_SLL = 3'd0,   // Logical left
      OP_SRL = 3'd1,   // Logical right
      OP_SRA = 3'd2,   // Arithmetic right
      OP_ROL = 3'd3,   // Rotate left
      OP_ROR = 3'd4    // Rotate right
   } shift_op_e;

   // Request from the issue side
   typedef struct packed {
      shift_op_e                   op;
      logic [`SHIFT_WIDTH-1:0]     value;
      logic [`SHIFT_AMT_BITS-1:0]  amount;
   } shift_req_t;

   // Decoded controls for the rotate datapath
   typedef struct packed {
      logic [`SHIFT_WIDTH-1:0]     value;
      logic [`SHIFT_AMT_BITS-1:0]  rot_amt;
      logic [`SHIFT_WIDTH-1:0]     keep_mask;  // 1 where a rotated bit survives
      logic                        fill;       // Bit placed where mask is 0
      logic                        carry_hi;   // Carry from rotated bit 31
      logic                        carry_en;   // Low for a zero amount
   } shift_ctl_t;

   typedef struct packed {
      logic [`SHIFT_WIDTH-1:0]     result;
      logic                        carry;
      logic                        zero;
      logic                        negative;
   } shift_rsp_t;

endpackage

// ==== hdl/shift_decode.sv ====
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_decode
   import shift_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        req_valid,
   input  shift_req_t  req,
   output logic        ctl_valid,
   output shift_ctl_t  ctl
);

   localparam logic [`SHIFT_WIDTH-1:0] ONES = '1;

   logic [`SHIFT_AMT_BITS-1:0] amt_neg;
   logic [`SHIFT_WIDTH-1:0]    mask_left;
   logic [`SHIFT_WIDTH-1:0]    mask_right;
   shift_ctl_t                 ctl_d;

   // Right shifts become a left rotate by (32 - n) mod 32
   assign amt_neg    = '0 - req.amount;
   assign mask_left  = ONES << req.amount;   // Bits n and above
   assign mask_right = ONES >> req.amount;   // Bits below 32 - n

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Operation decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      // Rotate left is the plain case
      ctl_d.value     = req.value;
      ctl_d.rot_amt   = req.amount;
      ctl_d.keep_mask = ONES;
      ctl_d.fill      = 1'b0;
      ctl_d.carry_hi  = 1'b0;
      ctl_d.carry_en  = |req.amount;

      case (req.op)
         OP_SLL: begin
            ctl_d.keep_mask = mask_left;
         end
         OP_SRL: begin
            ctl_d.rot_amt   = amt_neg;
            ctl_d.keep_mask = mask_right;
            ctl_d.carry_hi  = 1'b1;
         end
         OP_SRA: begin
            ctl_d.rot_amt   = amt_neg;
            ctl_d.keep_mask = mask_right;
            ctl_d.fill      = req.value[`SHIFT_WIDTH-1];   // Sign extend
            ctl_d.carry_hi  = 1'b1;
         end
         OP_ROR: begin
            ctl_d.rot_amt   = amt_neg;
            ctl_d.carry_hi  = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ctl_valid <= 1'b0;
      end else begin
         ctl_valid <= req_valid;
      end
      if (req_valid) begin
         ctl <= ctl_d;
      end
   end

   // Only the five defined encodings may be issued
   a_op_legal : assert property (
      @(posedge clk) disable iff (rst)
      req_valid |-> req.op inside {OP_SLL, OP_SRL, OP_SRA, OP_ROL, OP_ROR}
   );

endmodule

// ==== hdl/shift_rotator.sv ====
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_rotator (
   input  logic [`SHIFT_WIDTH-1:0]    value,
   input  logic [`SHIFT_AMT_BITS-1:0] amount,
   output logic [`SHIFT_WIDTH-1:0]    rotated
);

   localparam int W     = `SHIFT_WIDTH;
   localparam int LANES = 4;            // Bit position inside a nibble
   localparam int NIBS  = W / LANES;    // Nibbles per word

   logic [W-1:0] sa;
   logic [1:0]   fine;
   logic [2:0]   coarse;

   assign fine   = amount[1:0];
   assign coarse = amount[`SHIFT_AMT_BITS-1:2];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stage 1, rotate left by 0 to 3
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign sa =
      fine == 2'b00 ? value :
      fine == 2'b01 ? {value[W-2:0], value[W-1]} :
      fine == 2'b10 ? {value[W-3:0], value[W-1:W-2]} :
      {value[W-4:0], value[W-1:W-3]};

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stage 2, rotate left by 4 * coarse
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Each lane holds the same bit of every nibble, so a nibble
   // rotate is a one-step rotate of the lane
   for (genvar j = 0; j < LANES; j++) begin : g_lane
      logic [NIBS-1:0] lane_in;
      logic [NIBS-1:0] lane_out;

      for (genvar k = 0; k < NIBS; k++) begin : g_bit
         assign lane_in[k]              = sa[LANES*k + j];
         assign rotated[LANES*k + j]    = lane_out[k];
      end

      always_comb begin
         case (coarse)
            3'd0:    lane_out = lane_in;
            3'd1:    lane_out = {lane_in[6:0], lane_in[7]};
            3'd2:    lane_out = {lane_in[5:0], lane_in[7:6]};
            3'd3:    lane_out = {lane_in[4:0], lane_in[7:5]};
            3'd4:    lane_out = {lane_in[3:0], lane_in[7:4]};
            3'd5:    lane_out = {lane_in[2:0], lane_in[7:3]};
            3'd6:    lane_out = {lane_in[1:0], lane_in[7:2]};
            default: lane_out = {lane_in[0], lane_in[7:1]};
         endcase
      end
   end

endmodule

// ==== hdl/shift_merge.sv ====
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_merge
   import shift_pkg::*;
(
   input  logic [`SHIFT_WIDTH-1:0] rotated,
   input  shift_ctl_t              ctl,
   output shift_rsp_t              merged
);

   logic [`SHIFT_WIDTH-1:0] fill_word;
   logic [`SHIFT_WIDTH-1:0] kept;
   logic                    carry_bit;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Mask and fill
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wrapped bits are replaced by zeros or sign copies
   assign kept      = rotated & ctl.keep_mask;
   assign fill_word = {`SHIFT_WIDTH{ctl.fill}} & ~ctl.keep_mask;

   // Last bit out lands at one end of the rotated word
   assign carry_bit = ctl.carry_hi ? rotated[`SHIFT_WIDTH-1] : rotated[0];

   always_comb begin
      merged.result   = kept | fill_word;
      merged.carry    = carry_bit & ctl.carry_en;
      merged.zero     = 1'b0;   // Set on output side
      merged.negative = 1'b0;
   end

endmodule

// ==== hdl/shift_result.sv ====
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_result
   import shift_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        ctl_valid,
   input  shift_rsp_t  merged,
   output logic        rsp_valid,
   output shift_rsp_t  rsp
);

   shift_rsp_t rsp_d;

   always_comb begin
      rsp_d          = merged;
      rsp_d.zero     = ~|merged.result;
      rsp_d.negative = merged.result[`SHIFT_WIDTH-1];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= ctl_valid;   // One-cycle pulse per request
      end
      if (ctl_valid) begin
         rsp <= rsp_d;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Nothing left in the pipe may leak out after reset
   a_no_rsp_after_rst : assert property (
      @(posedge clk) $fell(rst) |=> !rsp_valid
   );

   a_flags_exclusive : assert property (
      @(posedge clk) disable iff (rst)
      rsp_valid |-> !(rsp.zero && rsp.negative)
   );

endmodule

// ==== hdl/shift_unit.sv ====
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_unit
   import shift_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        req_valid,
   input  shift_req_t  req,
   output logic        rsp_valid,
   output shift_rsp_t  rsp
);

   logic                    ctl_valid;
   shift_ctl_t              ctl;
   logic [`SHIFT_WIDTH-1:0] rotated;
   shift_rsp_t              merged;

   shift_decode u_decode (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req       (req),
      .ctl_valid (ctl_valid),
      .ctl       (ctl)
   );

   // Single rotator serves all operations
   shift_rotator u_rotator (
      .value   (ctl.value),
      .amount  (ctl.rot_amt),
      .rotated (rotated)
   );

   shift_merge u_merge (
      .rotated (rotated),
      .ctl     (ctl),
      .merged  (merged)
   );

   shift_result u_result (
      .clk       (clk),
      .rst       (rst),
      .ctl_valid (ctl_valid),
      .merged    (merged),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

endmodule

// ==== tb/shift_unit_tb.sv ====
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_unit_tb
   import shift_pkg::*;
;

   localparam int W           = `SHIFT_WIDTH;
   localparam int N_DIRECTED  = 95;
   localparam int N_RANDOM    = 400;
   localparam int N_REQ       = N_DIRECTED + N_RANDOM;
   localparam int TIMEOUT_CYC = 2 * N_REQ + 100;

   logic       clk = 1'b0;
   logic       rst;
   logic       req_valid;
   shift_req_t req;
   logic       rsp_valid;
   shift_rsp_t rsp;

   int          cyc = 0;
   int          n_issued = 0;
   int          n_value_err = 0;
   int          n_latency_err = 0;
   int          n_proto_err = 0;
   logic [15:0] lfsr = 16'd21450;
   shift_rsp_t  exp_q[$];
   int          cyc_q[$];   // Edge on which the DUT sampled each request

   shift_unit u_shift_unit (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYC) begin
         $display("Timeout after %0d cycles, %0d responses still missing", cyc, exp_q.size());
         $display("tests failed");
         $finish;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Random source and reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic next_bit();
      logic b;
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 16'hB400;   // Galois taps 16,14,13,11
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) r = {r[30:0], next_bit()};
      return r;
   endfunction

   function automatic shift_rsp_t shift_model(input shift_req_t r);
      shift_rsp_t      s;
      int              n;
      logic [W-1:0]    v;
      n       = int'(r.amount);
      v       = r.value;
      s.carry = 1'b0;
      case (r.op)
         OP_SLL: begin
            s.result = v << n;
            if (n != 0) s.carry = v[W-n];        // Last bit out the top
         end
         OP_SRL: begin
            s.result = v >> n;
            if (n != 0) s.carry = v[n-1];
         end
         OP_SRA: begin
            s.result = $signed(v) >>> n;
            if (n != 0) s.carry = v[n-1];
         end
         OP_ROL: begin
            s.result = (n == 0) ? v : ((v << n) | (v >> (W - n)));
            if (n != 0) s.carry = s.result[0];
         end
         OP_ROR: begin
            s.result = (n == 0) ? v : ((v >> n) | (v << (W - n)));
            if (n != 0) s.carry = s.result[W-1];
         end
         default: s.result = '0;
      endcase
      s.zero     = (s.result == 0);
      s.negative = s.result[W-1];
      return s;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus and checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic send_req(input shift_op_e op, input logic [W-1:0] value,
                           input logic [4:0] amount);
      shift_req_t r;
      r.op      = op;
      r.value   = value;
      r.amount  = amount;
      req_valid <= 1'b1;
      req       <= r;
      exp_q.push_back(shift_model(r));
      cyc_q.push_back(cyc + 1);   // Sampled on the next edge
      n_issued++;
      @(posedge clk);
   endtask

   task automatic idle_cycles(input int n);
      req_valid <= 1'b0;
      repeat (n) @(posedge clk);
   endtask

   task automatic check_rsp(input shift_rsp_t exp, input shift_rsp_t act);
      if (act !== exp) begin
         n_value_err++;
         $display("[ERROR] %0t: got result %h c%b z%b n%b, expected %h c%b z%b n%b", $time,
                  act.result, act.carry, act.zero, act.negative,
                  exp.result, exp.carry, exp.zero, exp.negative);
      end
   endtask

   task automatic check_latency(input int exp_cyc, input int act_cyc);
      if (act_cyc != exp_cyc) begin
         n_latency_err++;
         $display("[ERROR] %0t: response on cycle %0d, expected cycle %0d", $time,
                  act_cyc, exp_cyc);
      end
   endtask

   always @(posedge clk) begin : compare_rsp
      shift_rsp_t exp_rsp;
      int         exp_cyc;
      if (rst) begin
         if (cyc > 0 && rsp_valid !== 1'b0) begin
            n_proto_err++;
            $display("rsp_valid was not low during reset at %0t", $time);
         end
      end else if (rsp_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            n_proto_err++;
            $display("A response arrived at %0t with no request outstanding", $time);
         end else begin
            exp_rsp = exp_q.pop_front();
            exp_cyc = cyc_q.pop_front();
            check_rsp(exp_rsp, rsp);
            check_latency(exp_cyc + 2, cyc);
         end
      end
   end

   initial begin : main
      shift_op_e   ops [5] = '{OP_SLL, OP_SRL, OP_SRA, OP_ROL, OP_ROR};
      logic [4:0]  amts [5] = '{5'd1, 5'd4, 5'd5, 5'd16, 5'd31};
      logic [31:0] pats [2] = '{32'h8765_4321, 32'hA5C3_0F96};
      logic [31:0] negs [3] = '{32'h8000_0000, 32'hF0F0_1234, 32'hFFFF_FFFF};
      logic [31:0] bits;
      int          sent;
      int          burst;
      int          drain;
      rst       = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      // Zero amount leaves every value alone
      foreach (ops[i]) begin
         send_req(ops[i], 32'h8000_0001, 5'd0);
         send_req(ops[i], 32'hDEAD_BEEF, 5'd0);
      end
      // Both rotator stages and the mask edges
      foreach (ops[i])
         foreach (amts[j])
            foreach (pats[k]) send_req(ops[i], pats[k], amts[j]);
      idle_cycles(2);
      // Sign fill against zero fill
      foreach (negs[k])
         foreach (amts[j]) begin
            send_req(OP_SRA, negs[k], amts[j]);
            send_req(OP_SRL, negs[k], amts[j]);
         end
      // Flags
      send_req(OP_SLL, 32'h0000_0002, 5'd31);
      send_req(OP_SRL, 32'h4000_0000, 5'd31);
      send_req(OP_ROL, 32'h0000_0000, 5'd5);
      send_req(OP_SLL, 32'h0000_0001, 5'd31);
      send_req(OP_ROR, 32'h0000_0001, 5'd1);
      idle_cycles(3);

      // Random bursts with idle gaps in between
      sent = 0;
      while (sent < N_RANDOM) begin
         burst = 4 + int'(rand_bits(3));
         for (int i = 0; i < burst && sent < N_RANDOM; i++) begin
            shift_op_e   op;
            logic [31:0] value;
            logic [31:0] amt;
            bits  = rand_bits(3) % 32'd5;
            op    = shift_op_e'(bits[2:0]);
            value = rand_bits(32);
            amt   = rand_bits(5);
            send_req(op, value, amt[4:0]);
            sent++;
         end
         idle_cycles(1 + int'(rand_bits(2)));
      end
      req_valid <= 1'b0;

      drain = 0;
      while (exp_q.size() != 0 && drain < 10) begin
         @(posedge clk);
         drain++;
      end
      repeat (4) @(posedge clk);   // Catch stray responses

      if (n_issued != N_REQ) begin
         n_proto_err++;
         $display("Issued %0d requests where %0d were planned", n_issued, N_REQ);
      end
      if (exp_q.size() != 0) begin
         n_proto_err++;
         $display("%0d expected responses never arrived", exp_q.size());
      end
      $display("Errors: value %0d, latency %0d, protocol %0d",
               n_value_err, n_latency_err, n_proto_err);
      if (n_value_err + n_latency_err + n_proto_err == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/shift_pkg.sv
hdl/shift_decode.sv
hdl/shift_rotator.sv
hdl/shift_merge.sv
hdl/shift_result.sv
hdl/shift_unit.sv
tb/shift_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the shift unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f list.f --top-module shift_unit_tb -o shift_unit_sim

status=0
./obj_dir/shift_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit "$status"
fi
